//--- compile.f
rtl/isa_pkg.sv
rtl/uop_pkg.sv
rtl/instr_decoder.sv
rtl/ucode_sequencer.sv
rtl/uop_exec.sv
rtl/uop_frontend.sv
tb/uop_frontend_tb.sv

//--- rtl/instr_decoder.sv
module instr_decoder #(
    parameter int xlen = 32
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 instr_valid,
    input  isa_pkg::instr_word_u instr,
    output logic                 valid_de1,
    output logic                 trap_de1,
    output uop_pkg::uop_op_t     op_de1,
    output uop_pkg::reg_idx_t    dst_de1,
    output uop_pkg::reg_idx_t    src1_de1,
    output uop_pkg::reg_idx_t    src2_de1,
    output logic [xlen-1:0]      imm_de1,
    output logic                 use_imm_de1
);
    import isa_pkg::*;
    import uop_pkg::*;

    uop_op_t         op;
    reg_idx_t        dst;
    reg_idx_t        src1;
    reg_idx_t        src2;
    logic [xlen-1:0] imm;
    logic            use_imm;
    logic            trap;
    logic            bad_reg;

    always_comb begin
        op      = uop_nop;
        dst     = reg_x0;
        src1    = reg_x0;
        src2    = reg_x0;
        imm     = '0;
        use_imm = 1'b0;
        trap    = 1'b0;
        // rv32e only has x0-x15
        bad_reg = instr.r_fmt.rd[4] | instr.r_fmt.rs1[4];

        if (instr.r_fmt.opcode == opc_op && !bad_reg && !instr.r_fmt.rs2[4]) begin
            dst  = instr.r_fmt.rd;
            src1 = instr.r_fmt.rs1;
            src2 = instr.r_fmt.rs2;
            case ({instr.r_fmt.funct7, instr.r_fmt.funct3})
                {f7_base, f3_add_sub}:  op = uop_add;
                {f7_alt, f3_add_sub}:   op = uop_sub;
                {f7_base, f3_and}:      op = uop_and;
                {f7_base, f3_or}:       op = uop_or;
                {f7_base, f3_xor}:      op = uop_xor;
                {f7_muldiv, f3_mul}:    trap = 1'b1;
                default: ;
            endcase
        end else if (instr.i_fmt.opcode == opc_op_imm && !bad_reg) begin
            dst     = instr.i_fmt.rd;
            src1    = instr.i_fmt.rs1;
            use_imm = 1'b1;
            imm     = {{(xlen-12){instr.i_fmt.imm12[11]}}, instr.i_fmt.imm12};
            case (instr.i_fmt.funct3)
                f3_add_sub: op = uop_add;
                // shift immediates keep funct7 in the upper imm bits
                f3_sll:     if (instr.r_fmt.funct7 == f7_base) op = uop_sll;
                f3_srl_sra: if (instr.r_fmt.funct7 == f7_base) op = uop_srl;
                default: ;
            endcase
        end

        // unknown encodings write nothing
        if (op == uop_nop && !trap) begin
            dst = reg_x0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_de1 <= 1'b0;
            trap_de1  <= 1'b0;
        end else begin
            valid_de1 <= instr_valid;
            trap_de1  <= instr_valid & trap;
        end
    end

    always_ff @(posedge clk) begin
        op_de1      <= op;
        dst_de1     <= dst;
        src1_de1    <= src1;
        src2_de1    <= src2;
        imm_de1     <= imm;
        use_imm_de1 <= use_imm;
    end

endmodule

//--- rtl/isa_pkg.sv
package isa_pkg;

    // major opcodes
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;

    // funct3
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_mul     = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // funct7
    localparam logic [6:0] f7_base   = 7'b0000000;
    localparam logic [6:0] f7_alt    = 7'b0100000;
    localparam logic [6:0] f7_muldiv = 7'b0000001;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // same 32 bits, read through whichever format the opcode calls for
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_word_u;

endpackage

//--- rtl/ucode_sequencer.sv
module ucode_sequencer #(
    parameter int xlen = 32
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               valid_de1,
    input  logic               trap_de1,
    input  uop_pkg::uop_op_t   op_de1,
    input  uop_pkg::reg_idx_t  dst_de1,
    input  uop_pkg::reg_idx_t  src1_de1,
    input  uop_pkg::reg_idx_t  src2_de1,
    input  logic [xlen-1:0]    imm_de1,
    input  logic               use_imm_de1,
    input  logic               br_taken,
    input  uop_pkg::rom_addr_t br_target,
    output logic               seq_idle,
    output logic               valid_uc0,
    output uop_pkg::uop_op_t   op_uc0,
    output uop_pkg::reg_idx_t  dst_uc0,
    output uop_pkg::reg_idx_t  src1_uc0,
    output uop_pkg::reg_idx_t  src2_uc0,
    output logic [xlen-1:0]    imm_uc0,
    output logic               use_imm_uc0,
    output uop_pkg::br_off_t   br_off_uc0,
    output logic               eom_uc0
);
    import uop_pkg::*;

    localparam logic st_idle  = 1'b0;
    localparam logic st_fetch = 1'b1;
    localparam int   row_w    = 4 + 3 * (2 + 5) + xlen + 1 + 5 + 1;
    localparam int   e        = int'(rom_ent_mul);

    logic             state;
    logic             state_nxt;
    rom_addr_t        upc;
    rom_addr_t        upc_nxt;
    logic             trap_now;
    reg_idx_t         held_src1;
    reg_idx_t         held_src2;
    reg_idx_t         held_dst;
    logic [row_w-1:0] rom [ucode_rom_rows];

    // fields of the row under the pointer
    logic [3:0]       r_op;
    logic [1:0]       r_dst_k;
    logic [1:0]       r_src1_k;
    logic [1:0]       r_src2_k;
    reg_idx_t         r_dst;
    reg_idx_t         r_src1;
    reg_idx_t         r_src2;
    logic [xlen-1:0]  r_imm;
    logic             r_use_imm;
    br_off_t          r_br_off;
    logic             r_eom;

    function automatic logic [row_w-1:0] uop_ri(uop_op_t op, operand_kind_t dk, reg_idx_t d,
                                                operand_kind_t sk, reg_idx_t s,
                                                logic [xlen-1:0] imm, logic eom);
        return {op, dk, d, sk, s, opk_reg, reg_x0, imm, 1'b1, br_off_t'(0), eom};
    endfunction

    function automatic logic [row_w-1:0] uop_rr(uop_op_t op, reg_idx_t d, reg_idx_t s1,
                                                reg_idx_t s2);
        return {op, opk_reg, d, opk_reg, s1, opk_reg, s2, {xlen{1'b0}}, 1'b0, br_off_t'(0),
                1'b0};
    endfunction

    function automatic logic [row_w-1:0] uop_br(uop_op_t op, reg_idx_t s1, reg_idx_t s2,
                                                br_off_t off);
        return {op, opk_reg, reg_x0, opk_reg, s1, opk_reg, s2, {xlen{1'b0}}, 1'b0, off, 1'b0};
    endfunction

    function automatic reg_idx_t subst(operand_kind_t kind, reg_idx_t r, reg_idx_t s1,
                                       reg_idx_t s2, reg_idx_t d);
        case (kind)
            opk_trap_src1: return s1;
            opk_trap_src2: return s2;
            opk_trap_dst:  return d;
            default:       return r;
        endcase
    endfunction

    assign seq_idle = state == st_idle;
    assign trap_now = seq_idle & valid_de1 & trap_de1;

    always_comb begin
        state_nxt = state;
        upc_nxt   = upc;
        if (seq_idle) begin
            if (trap_now) begin
                state_nxt = st_fetch;
                upc_nxt   = rom_ent_mul;
            end
        end else begin
            upc_nxt = br_taken ? br_target : upc + 1'b1;
            if (eom_uc0) begin
                state_nxt = st_idle;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            upc   <= rom_ent_mul;
        end else begin
            state <= state_nxt;
            upc   <= upc_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (trap_now) begin
            held_src1 <= src1_de1;
            held_src2 <= src2_de1;
            held_dst  <= dst_de1;
        end
    end

    assign {r_op, r_dst_k, r_dst, r_src1_k, r_src1, r_src2_k, r_src2,
            r_imm, r_use_imm, r_br_off, r_eom} = rom[upc];

    always_comb begin
        if (seq_idle) begin
            // the trapping uop itself is swallowed
            valid_uc0   = valid_de1 & ~trap_de1;
            op_uc0      = op_de1;
            dst_uc0     = dst_de1;
            src1_uc0    = src1_de1;
            src2_uc0    = src2_de1;
            imm_uc0     = imm_de1;
            use_imm_uc0 = use_imm_de1;
            br_off_uc0  = '0;
            eom_uc0     = 1'b1;
        end else begin
            valid_uc0   = 1'b1;
            op_uc0      = uop_op_t'(r_op);
            dst_uc0     = subst(operand_kind_t'(r_dst_k), r_dst, held_src1, held_src2, held_dst);
            src1_uc0    = subst(operand_kind_t'(r_src1_k), r_src1, held_src1, held_src2,
                                held_dst);
            src2_uc0    = subst(operand_kind_t'(r_src2_k), r_src2, held_src1, held_src2,
                                held_dst);
            // branches carry their own row address for the target add
            if (op_uc0 == uop_beq || op_uc0 == uop_bne) begin
                imm_uc0 = {{(xlen-5){1'b0}}, upc};
            end else begin
                imm_uc0 = r_imm;
            end
            use_imm_uc0 = r_use_imm;
            br_off_uc0  = r_br_off;
            eom_uc0     = r_eom;
        end
    end

    // shift-and-add multiply
    always_comb begin
        for (int r = 0; r < ucode_rom_rows; r++) begin
            rom[r] = uop_ri(uop_nop, opk_reg, reg_x0, opk_reg, reg_x0, '0, 1'b1);
        end
        rom[e + 0]  = uop_ri(uop_add, opk_reg, reg_tmp0, opk_reg, reg_x0, '0, 1'b0);
        rom[e + 1]  = uop_ri(uop_add, opk_reg, reg_tmp1, opk_trap_src1, reg_x0, '0, 1'b0);
        rom[e + 2]  = uop_ri(uop_add, opk_reg, reg_tmp2, opk_trap_src2, reg_x0, '0, 1'b0);
        // zero multiplier skips straight to the move
        rom[e + 3]  = uop_br(uop_beq, reg_tmp1, reg_x0, 5'sd9);
        rom[e + 4]  = uop_ri(uop_and, opk_reg, reg_tmp3, opk_reg, reg_tmp1, 'd1, 1'b0);
        rom[e + 5]  = uop_ri(uop_sub, opk_reg, reg_tmp3, opk_reg, reg_tmp3, 'd1, 1'b0);
        // bit set gives all ones, clear gives zero
        rom[e + 6]  = uop_ri(uop_xor, opk_reg, reg_tmp3, opk_reg, reg_tmp3, '1, 1'b0);
        rom[e + 7]  = uop_rr(uop_and, reg_tmp4, reg_tmp3, reg_tmp2);
        rom[e + 8]  = uop_rr(uop_add, reg_tmp0, reg_tmp0, reg_tmp4);
        rom[e + 9]  = uop_ri(uop_sll, opk_reg, reg_tmp2, opk_reg, reg_tmp2, 'd1, 1'b0);
        rom[e + 10] = uop_ri(uop_srl, opk_reg, reg_tmp1, opk_reg, reg_tmp1, 'd1, 1'b0);
        rom[e + 11] = uop_br(uop_bne, reg_tmp1, reg_x0, -5'sd7);
        rom[e + 12] = uop_ri(uop_add, opk_trap_dst, reg_x0, opk_reg, reg_tmp0, '0, 1'b1);
    end

endmodule

//--- rtl/uop_exec.sv
module uop_exec #(
    parameter int xlen = 32
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               valid_uc0,
    input  uop_pkg::uop_op_t   op_uc0,
    input  uop_pkg::reg_idx_t  dst_uc0,
    input  uop_pkg::reg_idx_t  src1_uc0,
    input  uop_pkg::reg_idx_t  src2_uc0,
    input  logic [xlen-1:0]    imm_uc0,
    input  logic               use_imm_uc0,
    input  uop_pkg::br_off_t   br_off_uc0,
    input  logic               eom_uc0,
    output logic               br_taken,
    output uop_pkg::rom_addr_t br_target,
    output logic               wb_valid,
    output uop_pkg::reg_idx_t  wb_reg,
    output logic [xlen-1:0]    wb_data
);
    import uop_pkg::*;

    localparam int shamt_w = $clog2(xlen);

    logic [xlen-1:0] rf [num_regs];
    logic [xlen-1:0] a;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] b;
    logic [xlen-1:0] result;
    logic            is_alu;
    logic            writes;
    logic            visible;

    // x0 is hardwired
    assign a       = (src1_uc0 == reg_x0) ? '0 : rf[src1_uc0];
    assign rs2_val = (src2_uc0 == reg_x0) ? '0 : rf[src2_uc0];
    assign b       = use_imm_uc0 ? imm_uc0 : rs2_val;

    always_comb begin
        is_alu = 1'b1;
        case (op_uc0)
            uop_add: result = a + b;
            uop_sub: result = a - b;
            uop_and: result = a & b;
            uop_or:  result = a | b;
            uop_xor: result = a ^ b;
            uop_sll: result = a << b[shamt_w-1:0];
            uop_srl: result = a >> b[shamt_w-1:0];
            default: begin
                result = '0;
                is_alu = 1'b0;
            end
        endcase
    end

    // ucode branches resolve here, same cycle they issue
    always_comb begin
        case (op_uc0)
            uop_beq: br_taken = valid_uc0 & (a == rs2_val);
            uop_bne: br_taken = valid_uc0 & (a != rs2_val);
            default: br_taken = 1'b0;
        endcase
    end

    assign br_target = imm_uc0[4:0] + rom_addr_t'(br_off_uc0);

    assign writes  = valid_uc0 & is_alu & (dst_uc0 != reg_x0);
    assign visible = int'(dst_uc0) < num_arch_regs;

    always_ff @(posedge clk) begin
        if (writes) begin
            rf[dst_uc0] <= result;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            // temporaries never reach write-back
            wb_valid <= writes & eom_uc0 & visible;
        end
    end

    always_ff @(posedge clk) begin
        wb_reg  <= dst_uc0;
        wb_data <= result;
    end

endmodule

//--- rtl/uop_frontend.sv
module uop_frontend #(
    parameter int xlen = 32
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 instr_valid,
    input  isa_pkg::instr_word_u instr,
    output logic                 instr_ready,
    output logic                 wb_valid,
    output uop_pkg::reg_idx_t    wb_reg,
    output logic [xlen-1:0]      wb_data
);
    import uop_pkg::*;

    // de1 stage
    logic            valid_de1;
    logic            trap_de1;
    uop_op_t         op_de1;
    reg_idx_t        dst_de1;
    reg_idx_t        src1_de1;
    reg_idx_t        src2_de1;
    logic [xlen-1:0] imm_de1;
    logic            use_imm_de1;

    // uc0 stage
    logic            seq_idle;
    logic            valid_uc0;
    uop_op_t         op_uc0;
    reg_idx_t        dst_uc0;
    reg_idx_t        src1_uc0;
    reg_idx_t        src2_uc0;
    logic [xlen-1:0] imm_uc0;
    logic            use_imm_uc0;
    br_off_t         br_off_uc0;
    logic            eom_uc0;

    logic            br_taken;
    rom_addr_t       br_target;

    // hold off while a trap is pending or microcode is running
    assign instr_ready = seq_idle & ~trap_de1;

    instr_decoder #(.xlen(xlen)) instr_decoder_i (
        .clk, .reset, .instr_valid, .instr,
        .valid_de1, .trap_de1, .op_de1, .dst_de1, .src1_de1, .src2_de1,
        .imm_de1, .use_imm_de1
    );

    ucode_sequencer #(.xlen(xlen)) ucode_sequencer_i (
        .clk, .reset,
        .valid_de1, .trap_de1, .op_de1, .dst_de1, .src1_de1, .src2_de1,
        .imm_de1, .use_imm_de1, .br_taken, .br_target,
        .seq_idle, .valid_uc0, .op_uc0, .dst_uc0, .src1_uc0, .src2_uc0,
        .imm_uc0, .use_imm_uc0, .br_off_uc0, .eom_uc0
    );

    uop_exec #(.xlen(xlen)) uop_exec_i (
        .clk, .reset,
        .valid_uc0, .op_uc0, .dst_uc0, .src1_uc0, .src2_uc0,
        .imm_uc0, .use_imm_uc0, .br_off_uc0, .eom_uc0,
        .br_taken, .br_target, .wb_valid, .wb_reg, .wb_data
    );

endmodule

//--- rtl/uop_pkg.sv
package uop_pkg;

    typedef enum logic [3:0] {
        uop_add,
        uop_sub,
        uop_and,
        uop_or,
        uop_xor,
        uop_sll,
        uop_srl,
        uop_beq,
        uop_bne,
        uop_nop
    } uop_op_t;

    // trap_* kinds pick up the operands of the trapped instruction
    typedef enum logic [1:0] {
        opk_reg,
        opk_trap_src1,
        opk_trap_src2,
        opk_trap_dst
    } operand_kind_t;

    typedef logic [4:0] reg_idx_t;

    localparam reg_idx_t reg_x0   = 5'd0;
    localparam reg_idx_t reg_tmp0 = 5'd16;
    localparam reg_idx_t reg_tmp1 = 5'd17;
    localparam reg_idx_t reg_tmp2 = 5'd18;
    localparam reg_idx_t reg_tmp3 = 5'd19;
    localparam reg_idx_t reg_tmp4 = 5'd20;

    // x0-x15 visible, the rest are microcode temporaries
    localparam int num_arch_regs = 16;
    localparam int num_regs      = 24;

    typedef logic [4:0]        rom_addr_t;
    typedef logic signed [4:0] br_off_t;

    localparam int        ucode_rom_rows = 32;
    localparam rom_addr_t rom_ent_mul    = 5'd0;

endpackage

//--- run.sh
#!/bin/sh
# build and run from the project root, then decide on the log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing -f compile.f --top-module uop_frontend_tb -o uop_sim &&
./obj_dir/uop_sim | tee sim.log
grep -q "^RESULT: PASS$" sim.log && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}

//--- tb/uop_frontend_tb.sv
module uop_frontend_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import isa_pkg::*;
    import uop_pkg::*;

    localparam int          xlen           = 32;
    localparam int          max_vecs       = 64;
    localparam int          cycle_ns       = 100;
    localparam int          cycles_per_vec = 300;
    localparam logic [31:0] end_mark       = 32'hffffffff;

    logic            clk = 1'b0;
    logic            reset;
    logic            instr_valid;
    instr_word_u     instr;
    logic            instr_ready;
    logic            wb_valid;
    reg_idx_t        wb_reg;
    logic [xlen-1:0] wb_data;

    // each vector is an instruction word then its expected register and value
    logic [31:0]     vec_mem [3*max_vecs];
    int              n_vecs;
    logic            loaded = 1'b0;
    int              mismatches;
    int              failures;
    reg_idx_t        exp_regs [$];
    logic [xlen-1:0] exp_data [$];

    uop_frontend #(.xlen(xlen)) uop_frontend_i (
        .clk, .reset, .instr_valid, .instr, .instr_ready,
        .wb_valid, .wb_reg, .wb_data
    );

    always #50 clk = ~clk;

    task automatic check_reg(string name, reg_idx_t got, reg_idx_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_data(string name, logic [xlen-1:0] got, logic [xlen-1:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // holds the strobe for one cycle starting just after a rising edge
    task automatic send_instr(logic [31:0] word);
        while (instr_ready !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        instr_valid = 1'b1;
        instr       = word;
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
    endtask

    // compared mid-cycle away from the edge that updates it
    always @(negedge clk) begin
        if (reset === 1'b0 && wb_valid === 1'b1) begin
            if (exp_regs.size() == 0) begin
                failures++;
                $display("unexpected write-back to register %0d at %0t", wb_reg, $time);
            end else begin
                check_reg("wb_reg", wb_reg, exp_regs.pop_front());
                check_data("wb_data", wb_data, exp_data.pop_front());
            end
        end
    end

    initial begin : watchdog
        longint limit_ns;
        wait (loaded === 1'b1);
        limit_ns = longint'(n_vecs + 1) * cycles_per_vec * cycle_ns;
        #(limit_ns);
        $display("timeout: the run did not finish within %0d ns", limit_ns);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        mismatches  = 0;
        failures    = 0;

        $readmemh("tb/uop_vectors.txt", vec_mem);
        n_vecs = 0;
        while (n_vecs < max_vecs && vec_mem[3*n_vecs] == vec_mem[3*n_vecs] &&
               vec_mem[3*n_vecs] != end_mark) begin
            n_vecs++;
        end
        loaded = 1'b1;
        if (n_vecs == 0) begin
            failures++;
            $display("no vectors could be read from tb/uop_vectors.txt");
        end

        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        check_flag("instr_ready", instr_ready, 1'b1);
        check_flag("wb_valid", wb_valid, 1'b0);

        for (int i = 0; i < n_vecs; i++) begin
            // register zero in the file means no write-back
            if (vec_mem[3*i+1] != 32'd0) begin
                exp_regs.push_back(vec_mem[3*i+1][4:0]);
                exp_data.push_back(vec_mem[3*i+2]);
            end
            send_instr(vec_mem[3*i]);
        end

        // let the last write-back drain once the sequencer is idle
        while (instr_ready !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        repeat (3) @(posedge clk);

        if (exp_regs.size() != 0) begin
            failures++;
            $display("%0d expected write-backs never appeared", exp_regs.size());
        end

        $display("%0d vectors, %0d mismatches, %0d other failures",
                 n_vecs, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- tb/uop_vectors.txt
// instruction word, expected write-back register (00 = no write), expected value
// the line with instruction word ffffffff ends the list
00a00093 01 0000000a // addi x1, x0, 10
ffd00113 02 fffffffd // addi x2, x0, -3
7ff08193 03 00000809 // addi x3, x1, 2047
00409213 04 000000a0 // slli x4, x1, 4
01c15293 05 0000000f // srli x5, x2, 28
00208333 06 00000007 // add x6, x1, x2
403083b3 07 fffff801 // sub x7, x1, x3
0051f433 08 00000009 // and x8, x3, x5
005264b3 09 000000af // or x9, x4, x5
00114533 0a fffffff7 // xor x10, x2, x1
00508013 00 00000000 // addi x0, x1, 5
003005b3 0b 00000809 // add x11, x0, x3
02308633 0c 0000505a // mul x12, x1, x3
001606b3 0d 00005064 // add x13, x12, x1
02300733 0e 00000000 // mul x14, x0, x3 zero multiplier
020187b3 0f 00000000 // mul x15, x3, x0 zero multiplicand
02210733 0e 00000009 // mul x14, x2, x2
fff00093 01 ffffffff // addi x1, x0, -1
021487b3 0f ffffff51 // mul x15, x9, x1 all ones operand
023386b3 0d ffbfc009 // mul x13, x7, x3 large values
40e78333 06 ffffff48 // sub x6, x15, x14
0000000b 00 00000000 // unknown opcode
ffffffff 00 00000000 // end of list
